//--- cpu.f
+incdir+src
src/jvm_pkg.sv
src/mem_ifs.sv
src/stack.sv
src/lva.sv
src/control.sv
src/invoke_unit.sv
src/cpu.sv
test/cpu_tb.sv

//--- test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int cycle_limit = 5 * 2000;  // five programs of 2000 cycles each

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [7:0] op_code;
    logic [7:0] arg1;
    logic [7:0] arg2;
    jvm_pkg::word_t dataparams;
    logic [15:0] dataindex;
    jvm_pkg::pc_t program_counter;
    jvm_pkg::word_t retval;
    logic ret_valid;

    logic [7:0] prog_mem [0:65535];    // byte wide program memory
    jvm_pkg::word_t data_mem [0:65535];  // word wide data segment
    jvm_pkg::pc_t wp = '0;             // write pointer while a program is built
    jvm_pkg::pc_t final_ret = '0;      // address of the outermost return instruction
    jvm_pkg::word_t expected = '0;     // return value of the loaded program
    integer seed = 32'hd63a_1506;
    int unsigned cycles = 0;

    always #4 clk = ~clk;  // 8 ns period

    // combinational memory reads without wait states
    assign op_code    = prog_mem[program_counter];
    assign arg1       = prog_mem[program_counter + 16'd1];
    assign arg2       = prog_mem[program_counter + 16'd2];
    assign dataparams = data_mem[dataindex];

    cpu u_dut (
        .clk(clk),
        .rst(rst),
        .op_code(op_code),
        .arg1(arg1),
        .arg2(arg2),
        .dataparams(dataparams),
        .dataindex(dataindex),
        .program_counter(program_counter),
        .retval(retval),
        .ret_valid(ret_valid)
    );

    task automatic stop_on_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // every return strobe must carry the value worked out for the program
    retval_check: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (retval == expected))
        else stop_on_error($sformatf("retval %h, expected %h",
                                     $sampled(retval), $sampled(expected)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the program never returned within %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic jvm_pkg::word_t sext8(input logic [7:0] b);
        return {{24{b[7]}}, b};  // bipush sign extends its byte
    endfunction

    task automatic put_op(input logic [7:0] op);
        prog_mem[wp] = op;
        wp = wp + 16'd1;
    endtask

    task automatic put_op_byte(input logic [7:0] op, input logic [7:0] arg);
        put_op(op);
        put_op(arg);
    endtask

    task automatic put_op_word(input logic [7:0] op, input jvm_pkg::pc_t arg);
        put_op(op);
        put_op(arg[15:8]);  // big endian operand
        put_op(arg[7:0]);
    endtask

    // forward branch offset counts from the branch opcode
    task automatic patch_offset(input jvm_pkg::pc_t at, input jvm_pkg::pc_t target);
        jvm_pkg::pc_t rel;
        rel = target - at;
        prog_mem[at + 16'd1] = rel[15:8];
        prog_mem[at + 16'd2] = rel[7:0];
    endtask

    task automatic begin_program;
        @(posedge clk);
        rst <= 1'b1;  // previous program sits in halt
        wp = '0;
    endtask

    task automatic run_program;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (program_counter == 16'h0000 && !ret_valid)
            else stop_on_error("program_counter not 0 or ret_valid high after reset");
        do begin
            @(negedge clk);
        end while (!ret_valid);
        // the strobe belongs to the return of the outermost method
        assert (program_counter == final_ret)
            else stop_on_error($sformatf("ret_valid at pc %h, expected at pc %h",
                                         program_counter, final_ret));
        repeat (20) begin  // halt until the next reset
            @(negedge clk);
            assert (!ret_valid && program_counter == final_ret)
                else stop_on_error("cpu kept running or pulsed ret_valid after the outer return");
        end
    endtask

    task automatic arith_and_locals;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] k;
        a = 8'($random(seed));
        b = 8'($random(seed));
        k = 8'({$random(seed)} % 6);
        begin_program();
        put_op_byte(jvm_pkg::op_bipush, a);
        put_op_byte(jvm_pkg::op_istore, 8'd0);
        put_op(jvm_pkg::op_nop);
        put_op(8'h01);                          // not a kept opcode so it runs as nop
        put_op(jvm_pkg::op_iconst_0 + k);
        put_op_byte(jvm_pkg::op_istore, 8'd1);
        put_op_byte(jvm_pkg::op_iload, 8'd0);
        put_op_byte(jvm_pkg::op_iload, 8'd1);
        put_op(jvm_pkg::op_iadd);
        put_op_byte(jvm_pkg::op_bipush, b);
        put_op(jvm_pkg::op_isub);               // (a + k) - b
        final_ret = wp;
        put_op(jvm_pkg::op_ireturn);
        expected = sext8(a) + {24'h0, k} - sext8(b);
        run_program();
    endtask

    task automatic constant_load;
        logic [7:0] b;
        logic [15:0] idx;
        jvm_pkg::word_t c;
        b = 8'($random(seed));
        idx = 16'($random(seed));
        c = $random(seed);
        begin_program();
        data_mem[idx] = c;
        put_op_byte(jvm_pkg::op_bipush, b);
        put_op_word(jvm_pkg::op_ldc, idx);
        put_op(jvm_pkg::op_iadd);
        final_ret = wp;
        put_op(jvm_pkg::op_ireturn);
        expected = c + sext8(b);  // wraps at 32 bits
        run_program();
    endtask

    task automatic countdown_loop;
        logic [7:0] n;
        jvm_pkg::pc_t loop_at;
        jvm_pkg::pc_t exit_at;
        n = 8'(1 + {$random(seed)} % 20);
        begin_program();
        put_op_byte(jvm_pkg::op_bipush, n);
        put_op_byte(jvm_pkg::op_istore, 8'd0);      // local 0 counts down
        put_op(jvm_pkg::op_iconst_0);
        put_op_byte(jvm_pkg::op_istore, 8'd1);      // local 1 collects the sum
        loop_at = wp;
        put_op_byte(jvm_pkg::op_iload, 8'd0);
        exit_at = wp;
        put_op_word(jvm_pkg::op_ifeq, 16'h0000);    // target filled in below
        put_op_byte(jvm_pkg::op_iload, 8'd1);
        put_op(jvm_pkg::op_iconst_2);
        put_op(jvm_pkg::op_iadd);
        put_op_byte(jvm_pkg::op_istore, 8'd1);
        put_op_byte(jvm_pkg::op_iload, 8'd0);
        put_op(jvm_pkg::op_iconst_1);
        put_op(jvm_pkg::op_isub);
        put_op_byte(jvm_pkg::op_istore, 8'd0);
        put_op_word(jvm_pkg::op_goto, loop_at - wp);  // backward step
        patch_offset(exit_at, wp);
        put_op_byte(jvm_pkg::op_iload, 8'd1);
        final_ret = wp;
        put_op(jvm_pkg::op_ireturn);
        expected = {24'h0, n} * 2;
        run_program();
    endtask

    task automatic nested_calls;
        logic [7:0] x;
        logic [7:0] y;
        logic [15:0] idx1;
        logic [15:0] idx2;
        x = 8'($random(seed));
        y = 8'($random(seed));
        idx1 = 16'($random(seed));
        idx2 = idx1 + 16'd1;
        begin_program();
        data_mem[idx1] = {16'h0040, 8'd2, 8'd2};  // code, arg count, frame size
        data_mem[idx2] = {16'h0080, 8'd1, 8'd1};
        put_op_byte(jvm_pkg::op_bipush, x);
        put_op_byte(jvm_pkg::op_bipush, y);
        put_op_word(jvm_pkg::op_invokestatic, idx1);
        final_ret = wp;
        put_op(jvm_pkg::op_ireturn);
        wp = 16'h0040;                             // x minus y goes to the add five method
        put_op_byte(jvm_pkg::op_iload, 8'd0);
        put_op_byte(jvm_pkg::op_iload, 8'd1);
        put_op(jvm_pkg::op_isub);
        put_op_word(jvm_pkg::op_invokestatic, idx2);
        put_op(jvm_pkg::op_ireturn);
        wp = 16'h0080;
        put_op_byte(jvm_pkg::op_iload, 8'd0);
        put_op(jvm_pkg::op_iconst_5);
        put_op(jvm_pkg::op_iadd);
        put_op(jvm_pkg::op_ireturn);
        expected = sext8(x) - sext8(y) + 32'd5;
        run_program();
    endtask

    task automatic void_return;
        logic [7:0] x;
        logic [15:0] idx;
        x = 8'($random(seed));
        idx = 16'($random(seed));
        begin_program();
        data_mem[idx] = {16'h0040, 8'd1, 8'd2};
        put_op_byte(jvm_pkg::op_bipush, x);
        put_op_byte(jvm_pkg::op_istore, 8'd0);
        put_op_byte(jvm_pkg::op_iload, 8'd0);
        put_op_word(jvm_pkg::op_invokestatic, idx);
        final_ret = wp;
        put_op(jvm_pkg::op_return);               // outer return carries zero
        wp = 16'h0040;
        put_op_byte(jvm_pkg::op_iload, 8'd0);
        put_op(jvm_pkg::op_iconst_1);
        put_op(jvm_pkg::op_iadd);
        put_op_byte(jvm_pkg::op_istore, 8'd1);
        put_op(jvm_pkg::op_return);
        expected = '0;
        run_program();
    endtask

    initial begin
        for (int i = 0; i < 65536; i++) begin
            prog_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h6b;
            data_mem[i] = {16'(i) ^ 16'hc35a, ~16'(i)};
        end
        arith_and_locals();
        constant_load();
        countdown_loop();
        nested_calls();
        void_return();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- src/cpu.sv
`timescale 1ns/1ps
`include "jvm_settings.svh"

module cpu (
    input  logic           clk,
    input  logic           rst,
    input  logic [7:0]     op_code,
    input  logic [7:0]     arg1,
    input  logic [7:0]     arg2,
    input  jvm_pkg::word_t dataparams,
    output logic [15:0]    dataindex,
    output jvm_pkg::pc_t   program_counter,
    output jvm_pkg::word_t retval,
    output logic           ret_valid
);

    logic               op_done;
    jvm_pkg::pc_t       offset;         // pc step of the finished instruction
    logic               call_start;
    logic               call_done;
    logic               lva_move;       // move one argument into the new frame
    logic [7:0]         lva_move_index;
    logic               lva_move_done;
    logic               ret_start;
    logic               ret_done;
    logic               ret_top;
    jvm_pkg::lva_addr_t lva_offset;     // top of the current frame
    jvm_pkg::word_t     ldconst;

    stack_if eval_bus ();
    stack_if call_bus ();
    lva_if   lva_bus ();

    stack #(.DEPTH(`EVAL_DEPTH)) eval_stack (.clk(clk), .rst(rst), .bus(eval_bus.memory));
    stack #(.DEPTH(`CALL_DEPTH)) call_stack (.clk(clk), .rst(rst), .bus(call_bus.memory));
    lva   #(.SIZE(`LVA_SIZE))    local_vars (.clk(clk), .rst(rst), .bus(lva_bus.memory));

    control ctrl (
        .clk(clk), .rst(rst),
        .op_code(op_code), .arg1(arg1), .arg2(arg2),
        .eval(eval_bus.requester), .vars(lva_bus.requester),
        .lva_offset(lva_offset), .ldconst(ldconst),
        .op_done(op_done), .offset(offset),
        .call_start(call_start), .call_done(call_done),
        .lva_move(lva_move), .lva_move_index(lva_move_index),
        .lva_move_done(lva_move_done),
        .ret_start(ret_start), .ret_value(), .ret_has_value(),  // held inside control
        .ret_done(ret_done), .ret_top(ret_top),
        .retval(retval), .ret_valid(ret_valid)
    );

    invoke_unit invoke (
        .clk(clk), .rst(rst),
        .op_code(op_code), .arg1(arg1), .arg2(arg2), .dataparams(dataparams),
        .op_done(op_done), .offset(offset),
        .call_start(call_start), .call_done(call_done),
        .lva_move(lva_move), .lva_move_index(lva_move_index),
        .lva_move_done(lva_move_done),
        .ret_start(ret_start), .ret_done(ret_done), .ret_top(ret_top),
        .calls(call_bus.requester),
        .lva_offset(lva_offset), .ldconst(ldconst),
        .pc(program_counter), .dataindex(dataindex)
    );

endmodule

//--- src/invoke_unit.sv
`timescale 1ns/1ps
`include "jvm_settings.svh"

module invoke_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         op_code,
    input  logic [7:0]         arg1,
    input  logic [7:0]         arg2,
    input  jvm_pkg::word_t     dataparams,
    input  logic               op_done,
    input  jvm_pkg::pc_t       offset,
    input  logic               call_start,
    output logic               call_done,
    output logic               lva_move,
    output logic [7:0]         lva_move_index,
    input  logic               lva_move_done,
    input  logic               ret_start,
    output logic               ret_done,
    output logic               ret_top,
    stack_if.requester         calls,
    output jvm_pkg::lva_addr_t lva_offset,
    output jvm_pkg::word_t     ldconst,
    output jvm_pkg::pc_t       pc,
    output logic [15:0]        dataindex
);

    typedef enum logic [2:0] {
        inv_idle, inv_params, inv_move, inv_move_wait, inv_push_wait, inv_pop_wait
    } inv_state_t;

    inv_state_t state;
    jvm_pkg::pc_t   code_addr;           // entry of the invoked method
    jvm_pkg::frame_t popped;
    logic [7:0]     args_left;           // arguments still on the eval stack
    logic [15:0]    param_index;         // data word of the invoke parameters
    logic [$clog2(`CALL_DEPTH):0] depth; // frames on the call stack
    logic           is_ldc;

    assign is_ldc    = (op_code == jvm_pkg::op_ldc);
    assign dataindex = is_ldc ? {arg1, arg2} : param_index;
    assign popped    = calls.read_value;

    // constant follows the data segment while ldc executes
    always_ff @(posedge clk) begin
        if (is_ldc) begin
            ldconst <= dataparams;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= inv_idle;
            pc            <= '0;
            lva_offset    <= `MAIN_LOCALS;
            depth         <= '0;
            call_done     <= 1'b0;
            lva_move      <= 1'b0;
            ret_done      <= 1'b0;
            ret_top       <= 1'b0;
            calls.trigger <= 1'b0;
        end else begin
            call_done     <= 1'b0;
            lva_move      <= 1'b0;
            ret_done      <= 1'b0;
            ret_top       <= 1'b0;
            calls.trigger <= 1'b0;
            case (state)
                inv_idle: begin
                    if (op_done) begin
                        pc <= pc + offset;  // signed step wraps
                    end
                    if (call_start) begin
                        param_index <= {arg1, arg2};
                        state       <= inv_params;
                    end
                    if (ret_start) begin
                        if (depth == '0) begin
                            ret_top <= 1'b1;  // outermost method is done
                        end else begin
                            calls.push    <= 1'b0;
                            calls.trigger <= 1'b1;
                            state         <= inv_pop_wait;
                        end
                    end
                end
                inv_params: begin  // {code addr, arg count, frame size}
                    code_addr         <= dataparams[31:16];
                    args_left         <= dataparams[15:8];
                    calls.write_value <= {pc + 16'd3, 8'h00, lva_offset};  // caller frame
                    lva_offset        <= lva_offset + dataparams[7:0];
                    state             <= inv_move;
                end
                inv_move: begin
                    if (args_left != '0) begin
                        lva_move       <= 1'b1;
                        lva_move_index <= args_left - 8'd1;  // last argument sits on top
                        state          <= inv_move_wait;
                    end else begin
                        calls.push    <= 1'b1;
                        calls.trigger <= 1'b1;
                        state         <= inv_push_wait;
                    end
                end
                inv_move_wait: begin
                    if (lva_move_done) begin
                        args_left <= args_left - 8'd1;
                        state     <= inv_move;
                    end
                end
                inv_push_wait: begin
                    if (calls.done) begin
                        pc        <= code_addr;
                        depth     <= depth + 1'b1;
                        call_done <= 1'b1;
                        state     <= inv_idle;
                    end
                end
                inv_pop_wait: begin
                    if (calls.done) begin
                        pc         <= popped[31:16];
                        lva_offset <= popped[7:0];
                        depth      <= depth - 1'b1;
                        ret_done   <= 1'b1;
                        state      <= inv_idle;
                    end
                end
                default: state <= inv_idle;
            endcase
        end
    end

endmodule

//--- src/control.sv
`timescale 1ns/1ps
`include "jvm_settings.svh"

module control (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         op_code,
    input  logic [7:0]         arg1,
    input  logic [7:0]         arg2,
    stack_if.requester         eval,
    lva_if.requester           vars,
    input  jvm_pkg::lva_addr_t lva_offset,
    input  jvm_pkg::word_t     ldconst,
    output logic               op_done,
    output jvm_pkg::pc_t       offset,
    output logic               call_start,
    input  logic               call_done,
    input  logic               lva_move,
    input  logic [7:0]         lva_move_index,
    output logic               lva_move_done,
    output logic               ret_start,
    output jvm_pkg::word_t     ret_value,
    output logic               ret_has_value,
    input  logic               ret_done,
    input  logic               ret_top,
    output jvm_pkg::word_t     retval,
    output logic               ret_valid
);

    jvm_pkg::ctrl_state_t state;
    jvm_pkg::op_t   op;
    jvm_pkg::word_t push_val;  // next value for the eval stack
    jvm_pkg::word_t opb;       // top operand of iadd/isub
    jvm_pkg::pc_t   next_off;  // pc increment after the final push
    logic step;                // second access of istore, iadd, isub, lva move
    logic from_ldc;            // push takes the constant register
    logic ret_push;            // return value pushed into the caller frame

    assign op = jvm_pkg::op_t'(op_code);
    assign eval.write_value = from_ldc ? ldconst : push_val;
    assign vars.write_value = eval.read_value;  // lva writes store the last popped word

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= jvm_pkg::fetch;
            op_done       <= 1'b0;
            call_start    <= 1'b0;
            lva_move_done <= 1'b0;
            ret_start     <= 1'b0;
            ret_valid     <= 1'b0;
            eval.trigger  <= 1'b0;
            vars.trigger  <= 1'b0;
        end else begin
            op_done       <= 1'b0;  // all strobes one cycle
            call_start    <= 1'b0;
            lva_move_done <= 1'b0;
            ret_start     <= 1'b0;
            ret_valid     <= 1'b0;
            eval.trigger  <= 1'b0;
            vars.trigger  <= 1'b0;
            case (state)
                jvm_pkg::fetch: state <= jvm_pkg::exec;
                jvm_pkg::exec: begin
                    step     <= 1'b0;
                    from_ldc <= 1'b0;
                    ret_push <= 1'b0;
                    case (op)
                        jvm_pkg::op_iconst_0, jvm_pkg::op_iconst_1, jvm_pkg::op_iconst_2,
                        jvm_pkg::op_iconst_3, jvm_pkg::op_iconst_4, jvm_pkg::op_iconst_5,
                        jvm_pkg::op_bipush, jvm_pkg::op_ldc: begin
                            push_val <= (op == jvm_pkg::op_bipush)
                                ? {{(`WORD_W-8){arg1[7]}}, arg1}           // sign extended byte
                                : {{(`WORD_W-8){1'b0}}, op_code - 8'd3};  // iconst value
                            next_off <= (op == jvm_pkg::op_bipush) ? 16'd2
                                      : (op == jvm_pkg::op_ldc) ? 16'd3 : 16'd1;
                            from_ldc     <= (op == jvm_pkg::op_ldc);
                            eval.push    <= 1'b1;
                            eval.trigger <= 1'b1;
                            state        <= jvm_pkg::push_result;
                        end
                        jvm_pkg::op_iload: begin
                            vars.write   <= 1'b0;
                            vars.addr    <= lva_offset - arg1 - 8'd1;  // frame grows downward
                            vars.trigger <= 1'b1;
                            state        <= jvm_pkg::mem_wait;
                        end
                        jvm_pkg::op_istore, jvm_pkg::op_iadd, jvm_pkg::op_isub,
                        jvm_pkg::op_ifeq, jvm_pkg::op_ireturn: begin
                            eval.push    <= 1'b0;  // pop first operand
                            eval.trigger <= 1'b1;
                            state        <= jvm_pkg::mem_wait;
                        end
                        jvm_pkg::op_goto: begin
                            op_done <= 1'b1;
                            offset  <= {arg1, arg2};
                            state   <= jvm_pkg::fetch;
                        end
                        jvm_pkg::op_invokestatic: begin
                            call_start <= 1'b1;
                            state      <= jvm_pkg::call_wait;
                        end
                        jvm_pkg::op_return: begin
                            ret_value     <= '0;
                            ret_has_value <= 1'b0;
                            ret_start     <= 1'b1;
                            state         <= jvm_pkg::ret_wait;
                        end
                        default: begin  // nop and anything unknown
                            op_done <= 1'b1;
                            offset  <= 16'd1;
                            state   <= jvm_pkg::fetch;
                        end
                    endcase
                end
                jvm_pkg::mem_wait: begin
                    if (eval.done || vars.done) begin
                        case (op)
                            jvm_pkg::op_iload: begin
                                push_val     <= vars.read_value;
                                next_off     <= 16'd2;
                                eval.push    <= 1'b1;
                                eval.trigger <= 1'b1;
                                state        <= jvm_pkg::push_result;
                            end
                            jvm_pkg::op_istore: begin
                                if (!step) begin
                                    vars.write   <= 1'b1;
                                    vars.addr    <= lva_offset - arg1 - 8'd1;
                                    vars.trigger <= 1'b1;
                                    step         <= 1'b1;
                                end else begin
                                    op_done <= 1'b1;
                                    offset  <= 16'd2;
                                    state   <= jvm_pkg::fetch;
                                end
                            end
                            jvm_pkg::op_iadd, jvm_pkg::op_isub: begin
                                if (!step) begin
                                    opb          <= eval.read_value;
                                    eval.push    <= 1'b0;  // second operand
                                    eval.trigger <= 1'b1;
                                    step         <= 1'b1;
                                end else begin
                                    push_val <= (op == jvm_pkg::op_iadd)
                                        ? eval.read_value + opb
                                        : eval.read_value - opb;  // deeper minus top, wraps
                                    next_off     <= 16'd1;
                                    eval.push    <= 1'b1;
                                    eval.trigger <= 1'b1;
                                    state        <= jvm_pkg::push_result;
                                end
                            end
                            jvm_pkg::op_ifeq: begin
                                op_done <= 1'b1;
                                offset  <= (eval.read_value == '0) ? {arg1, arg2} : 16'd3;
                                state   <= jvm_pkg::fetch;
                            end
                            jvm_pkg::op_ireturn: begin
                                ret_value     <= eval.read_value;
                                ret_has_value <= 1'b1;
                                ret_start     <= 1'b1;
                                state         <= jvm_pkg::ret_wait;
                            end
                            jvm_pkg::op_invokestatic: begin
                                if (!step) begin
                                    vars.write   <= 1'b1;  // addr latched in call_wait
                                    vars.trigger <= 1'b1;
                                    step         <= 1'b1;
                                end else begin
                                    lva_move_done <= 1'b1;
                                    state         <= jvm_pkg::call_wait;
                                end
                            end
                            default: state <= jvm_pkg::fetch;
                        endcase
                    end
                end
                jvm_pkg::push_result: begin
                    if (eval.done) begin
                        if (!ret_push) begin  // pc already restored after a return
                            op_done <= 1'b1;
                            offset  <= next_off;
                        end
                        state <= jvm_pkg::fetch;
                    end
                end
                jvm_pkg::call_wait: begin
                    if (lva_move) begin
                        vars.addr    <= lva_offset - lva_move_index - 8'd1;
                        eval.push    <= 1'b0;
                        eval.trigger <= 1'b1;
                        step         <= 1'b0;
                        state        <= jvm_pkg::mem_wait;
                    end else if (call_done) begin
                        state <= jvm_pkg::fetch;  // pc holds the method entry
                    end
                end
                jvm_pkg::ret_wait: begin
                    if (ret_top) begin
                        retval    <= ret_value;
                        ret_valid <= 1'b1;
                        state     <= jvm_pkg::halt;
                    end else if (ret_done) begin
                        if (ret_has_value) begin
                            push_val     <= ret_value;
                            ret_push     <= 1'b1;
                            eval.push    <= 1'b1;
                            eval.trigger <= 1'b1;
                            state        <= jvm_pkg::push_result;
                        end else begin
                            state <= jvm_pkg::fetch;
                        end
                    end
                end
                jvm_pkg::halt: state <= jvm_pkg::halt;  // until reset
                default: state <= jvm_pkg::fetch;
            endcase
        end
    end

endmodule

//--- src/lva.sv
`timescale 1ns/1ps

module lva #(
    parameter int SIZE = 256
) (
    input logic   clk,
    input logic   rst,
    lva_if.memory bus
);

    jvm_pkg::word_t mem [SIZE];

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.trigger;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.trigger) begin
            if (bus.write) begin
                mem[bus.addr] <= bus.write_value;
            end else begin
                bus.read_value <= mem[bus.addr];  // ready with done
            end
        end
    end

endmodule

//--- src/stack.sv
`timescale 1ns/1ps

module stack #(
    parameter int DEPTH = 32
) (
    input logic     clk,
    input logic     rst,
    stack_if.memory bus
);

    jvm_pkg::word_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] sp;  // next free entry

    always_ff @(posedge clk) begin
        if (rst) begin
            sp       <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.trigger;  // answer one cycle later
            if (bus.trigger) begin
                if (bus.push) begin
                    sp <= sp + 1'b1;
                end else begin
                    sp <= sp - 1'b1;
                end
            end
        end
    end

    // storage, read value stays until the next pop
    always_ff @(posedge clk) begin
        if (bus.trigger) begin
            if (bus.push) begin
                mem[sp] <= bus.write_value;
            end else begin
                bus.read_value <= mem[sp - 1'b1];  // top entry
            end
        end
    end

endmodule

//--- src/mem_ifs.sv
`timescale 1ns/1ps

// lifo access, done follows trigger by one cycle
interface stack_if;
    logic           push;         // high push, low pop
    logic           trigger;      // one cycle request
    jvm_pkg::word_t write_value;
    jvm_pkg::word_t read_value;   // valid in the done cycle of a pop
    logic           done;

    modport requester (
        output push, trigger, write_value,
        input  read_value, done
    );
    modport memory (
        input  push, trigger, write_value,
        output read_value, done
    );
endinterface

// local variable array access, same handshake
interface lva_if;
    logic               write;    // high write, low read
    logic               trigger;
    jvm_pkg::lva_addr_t addr;
    jvm_pkg::word_t     write_value;
    jvm_pkg::word_t     read_value;
    logic               done;

    modport requester (
        output write, trigger, addr, write_value,
        input  read_value, done
    );
    modport memory (
        input  write, trigger, addr, write_value,
        output read_value, done
    );
endinterface

//--- src/jvm_pkg.sv
package jvm_pkg;

    typedef logic [31:0] word_t;      // one operand value
    typedef logic [15:0] pc_t;        // byte address in program memory
    typedef logic [7:0]  lva_addr_t;  // absolute local variable address
    typedef logic [31:0] frame_t;     // {return address, saved frame offset}

    // kept opcodes, standard java byte values
    typedef enum logic [7:0] {
        op_nop          = 8'h00,
        op_iconst_0     = 8'h03,
        op_iconst_1     = 8'h04,
        op_iconst_2     = 8'h05,
        op_iconst_3     = 8'h06,
        op_iconst_4     = 8'h07,
        op_iconst_5     = 8'h08,
        op_bipush       = 8'h10,
        op_ldc          = 8'h12,
        op_iload        = 8'h15,
        op_istore       = 8'h36,
        op_iadd         = 8'h60,
        op_isub         = 8'h64,
        op_ifeq         = 8'h99,
        op_goto         = 8'ha7,
        op_ireturn      = 8'hac,
        op_return       = 8'hb1,
        op_invokestatic = 8'hb8
    } op_t;

    typedef enum logic [2:0] {
        fetch,        // new pc settles
        exec,         // decode and start
        mem_wait,     // pop or lva access in flight
        push_result,  // final push in flight
        call_wait,    // invoke sequence running, serves lva moves
        ret_wait,     // return sequence running
        halt          // outermost method returned
    } ctrl_state_t;

endpackage

//--- src/jvm_settings.svh
`ifndef JVM_SETTINGS_SVH
`define JVM_SETTINGS_SVH

`define WORD_W      32
`define EVAL_DEPTH  32   // evaluation stack entries
`define CALL_DEPTH  64   // call stack frames
`define LVA_SIZE    256  // local variable words, all frames
`define MAIN_LOCALS 4    // frame size of the outermost method

`endif
